/* rv_isa_pkg.sv */
// RV32I instruction encodings

package rv_isa_pkg;

    ////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011
    } opcode_t;

    // Operations of the integer unit
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_t;

    ////////////////////////////////////////
    // funct3 / funct7 fields
    ////////////////////////////////////////

    localparam logic [2:0] FUNCT3_ADD = 3'b000;
    localparam logic [2:0] FUNCT3_SLL = 3'b001;
    localparam logic [2:0] FUNCT3_SLT = 3'b010;
    localparam logic [2:0] FUNCT3_XOR = 3'b100;
    localparam logic [2:0] FUNCT3_SRL = 3'b101;
    localparam logic [2:0] FUNCT3_OR  = 3'b110;
    localparam logic [2:0] FUNCT3_AND = 3'b111;

    localparam logic [2:0] FUNCT3_BEQ = 3'b000;
    localparam logic [2:0] FUNCT3_BNE = 3'b001;
    localparam logic [2:0] FUNCT3_BLT = 3'b100;

    localparam logic [2:0] FUNCT3_SW  = 3'b010;

    localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

    // SYSTEM immediates
    localparam logic [11:0] IMM_ECALL  = 12'h000;
    localparam logic [11:0] IMM_EBREAK = 12'h001;

endpackage

/* rv_core_pkg.sv */
// Core widths and controller definitions

package rv_core_pkg;

    ////////////////////////////////////////
    // Widths and boot
    ////////////////////////////////////////

    localparam int XLEN   = 32;
    localparam int ILEN   = 32;
    localparam int REG_AW = 5;

    // First fetch address out of reset
    localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_0000;

    // Controller sequence, one instruction at a time
    typedef enum logic [1:0] {
        S_FETCH,
        S_WAIT,
        S_EXEC,
        S_HALT
    } ctrl_state_t;

    ////////////////////////////////////////
    // Sticky trap status
    ////////////////////////////////////////

    localparam int STATUS_W   = 3;
    localparam int ST_ECALL   = 0;
    localparam int ST_EBREAK  = 1;
    localparam int ST_ILLEGAL = 2;

endpackage

/* rv_control.sv */
// Central controller, fetch and execute sequencing
`timescale 1ns/10ps

module rv_control (
    input  logic                             aclk,
    input  logic                             arst_n,
    input  logic                             imem_rvalid,
    input  logic [rv_core_pkg::ILEN-1:0]     imem_rdata,
    input  logic                             cond_true,
    input  logic [rv_core_pkg::XLEN-1:0]     alu_result,
    output logic                             imem_req,
    output logic                             dmem_wstrobe,
    output logic                             rd_wr,
    output logic                             alu_use_imm,
    output logic                             pc_inc,
    output logic                             pc_load,
    output logic [rv_core_pkg::REG_AW-1:0]   rs1_addr,
    output logic [rv_core_pkg::REG_AW-1:0]   rs2_addr,
    output logic [rv_core_pkg::REG_AW-1:0]   rd_addr,
    output logic [rv_core_pkg::XLEN-1:0]     rd_val,
    output rv_isa_pkg::alu_op_t              alu_op,
    output logic [rv_core_pkg::XLEN-1:0]     imm,
    output logic [2:0]                       branch_funct3,
    output logic [rv_core_pkg::STATUS_W-1:0] status
);
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    ctrl_state_t     state;
    ctrl_state_t     state_next;
    logic [ILEN-1:0] instr;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            is_op;
    logic            is_op_imm;
    logic            is_lui;
    logic            is_store;
    logic            is_branch;
    logic            is_ecall;
    logic            is_ebreak;
    logic            is_illegal;
    logic            exec;
    logic            trap;

    ////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////

    assign opcode        = instr[6:0];
    assign funct3        = instr[14:12];
    assign funct7        = instr[31:25];
    assign rd_addr       = instr[11:7];
    assign rs1_addr      = instr[19:15];
    assign rs2_addr      = instr[24:20];
    assign branch_funct3 = funct3;

    // Only the kept subset decodes as legal
    always_comb begin
        is_op     = 1'b0;
        is_op_imm = 1'b0;
        is_lui    = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        is_ecall  = 1'b0;
        is_ebreak = 1'b0;
        case (opcode)
            OP: begin
                if (funct7 == 7'b0) begin
                    is_op = funct3 inside {FUNCT3_ADD, FUNCT3_SLT, FUNCT3_XOR, FUNCT3_OR,
                                           FUNCT3_AND, FUNCT3_SLL, FUNCT3_SRL};
                end else if (funct7 == FUNCT7_SUB) begin
                    is_op = (funct3 == FUNCT3_ADD);
                end
            end
            OP_IMM: begin
                is_op_imm = funct3 inside {FUNCT3_ADD, FUNCT3_SLT, FUNCT3_XOR, FUNCT3_OR,
                                           FUNCT3_AND};
            end
            LUI:    is_lui    = 1'b1;
            STORE:  is_store  = (funct3 == FUNCT3_SW);
            BRANCH: is_branch = funct3 inside {FUNCT3_BEQ, FUNCT3_BNE, FUNCT3_BLT};
            SYSTEM: begin
                // rd, funct3 and rs1 must all be zero
                if (instr[19:7] == 13'b0) begin
                    is_ecall  = (instr[31:20] == IMM_ECALL);
                    is_ebreak = (instr[31:20] == IMM_EBREAK);
                end
            end
            default: ;
        endcase
    end

    assign is_illegal = !(is_op || is_op_imm || is_lui || is_store || is_branch ||
                          is_ecall || is_ebreak);

    // SW shares funct3 with SLT, so stores force an add
    always_comb begin
        case (funct3)
            FUNCT3_SLT: alu_op = ALU_SLT;
            FUNCT3_XOR: alu_op = ALU_XOR;
            FUNCT3_OR:  alu_op = ALU_OR;
            FUNCT3_AND: alu_op = ALU_AND;
            FUNCT3_SLL: alu_op = ALU_SLL;
            FUNCT3_SRL: alu_op = ALU_SRL;
            default:    alu_op = (is_op && funct7 == FUNCT7_SUB) ? ALU_SUB : ALU_ADD;
        endcase
        if (is_store) begin
            alu_op = ALU_ADD;
        end
    end

    // Sign-extended immediate per format
    always_comb begin
        case (opcode)
            STORE:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            BRANCH:  imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            LUI:     imm = {instr[31:12], 12'b0};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    assign alu_use_imm = is_op_imm || is_store;

    ////////////////////////////////////////
    // Execute strobes
    ////////////////////////////////////////

    assign exec         = (state == S_EXEC);
    assign trap         = is_ecall || is_ebreak || is_illegal;
    assign imem_req     = arst_n && (state == S_FETCH);
    assign rd_wr        = exec && (is_op || is_op_imm || is_lui);
    assign rd_val       = is_lui ? imm : alu_result;
    assign dmem_wstrobe = exec && is_store;
    assign pc_load      = exec && is_branch && cond_true;
    assign pc_inc       = exec && !trap && !pc_load;

    always_comb begin
        state_next = state;
        case (state)
            S_FETCH: state_next = S_WAIT;
            S_WAIT:  if (imem_rvalid) state_next = S_EXEC;
            S_EXEC:  state_next = trap ? S_HALT : S_FETCH;
            S_HALT:  state_next = S_HALT;
            default: state_next = S_HALT;
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= S_FETCH;
            status <= '0;
        end else begin
            state <= state_next;
            if (exec) begin
                status[ST_ECALL]   <= status[ST_ECALL]   | is_ecall;
                status[ST_EBREAK]  <= status[ST_EBREAK]  | is_ebreak;
                status[ST_ILLEGAL] <= status[ST_ILLEGAL] | is_illegal;
            end
        end
    end

    // Instruction word, captured on the fetch response
    always_ff @(posedge aclk) begin
        if (state == S_WAIT && imem_rvalid) begin
            instr <= imem_rdata;
        end
    end

    ////////////////////////////////////////
    // Protocol checks
    ////////////////////////////////////////

    // Memory answers only an outstanding request
    a_rvalid_in_wait: assert property (@(posedge aclk) disable iff (!arst_n)
        imem_rvalid |-> state == S_WAIT);

endmodule

/* rv_pc_counter.sv */
// Program counter
`timescale 1ns/10ps

module rv_pc_counter (
    input  logic                         aclk,
    input  logic                         arst_n,
    input  logic                         pc_inc,
    input  logic                         pc_load,
    input  logic [rv_core_pkg::XLEN-1:0] imm,
    output logic [rv_core_pkg::XLEN-1:0] pc
);
    import rv_core_pkg::*;

    localparam logic [XLEN-1:0] INST_BYTES = XLEN'(4);

    // Branch target is relative to the branch itself
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= BOOT_ADDR;
        end else if (pc_load) begin
            pc <= pc + imm;
        end else if (pc_inc) begin
            pc <= pc + INST_BYTES;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    a_one_update: assert property (@(posedge aclk) disable iff (!arst_n)
        !(pc_inc && pc_load));

    // A taken branch with a bad offset would break fetch alignment
    a_pc_aligned: assert property (@(posedge aclk) disable iff (!arst_n)
        pc[1:0] == 2'b00);

endmodule

/* rv_regfile.sv */
// Integer register file
`timescale 1ns/10ps

module rv_regfile (
    input  logic                           aclk,
    input  logic                           arst_n,
    input  logic                           rd_wr,
    input  logic [rv_core_pkg::REG_AW-1:0] rs1_addr,
    input  logic [rv_core_pkg::REG_AW-1:0] rs2_addr,
    input  logic [rv_core_pkg::REG_AW-1:0] rd_addr,
    input  logic [rv_core_pkg::XLEN-1:0]   rd_val,
    output logic [rv_core_pkg::XLEN-1:0]   rs1_val,
    output logic [rv_core_pkg::XLEN-1:0]   rs2_val
);
    import rv_core_pkg::*;

    localparam int NB_REGS = 2 ** REG_AW;

    // x1 to x31, x0 has no storage
    logic [XLEN-1:0] regs [NB_REGS-1:1];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < NB_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wr && rd_addr != '0) begin
            regs[rd_addr] <= rd_val;
        end
    end

    ////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////

    // x0 always reads zero
    assign rs1_val = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_val = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* rv_alu.sv */
// Integer processing unit
`timescale 1ns/10ps

module rv_alu (
    input  rv_isa_pkg::alu_op_t          alu_op,
    input  logic                         alu_use_imm,
    input  logic [rv_core_pkg::XLEN-1:0] rs1_val,
    input  logic [rv_core_pkg::XLEN-1:0] rs2_val,
    input  logic [rv_core_pkg::XLEN-1:0] imm,
    input  logic [2:0]                   branch_funct3,
    output logic [rv_core_pkg::XLEN-1:0] alu_result,
    output logic                         cond_true
);
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    logic [XLEN-1:0] opnd_b;
    logic [4:0]      shamt;
    logic            lt_signed;

    assign opnd_b = alu_use_imm ? imm : rs2_val;
    assign shamt  = opnd_b[4:0];

    // Shared by SLT and the signed result column
    assign lt_signed = $signed(rs1_val) < $signed(opnd_b);

    ////////////////////////////////////////
    // Arithmetic and logic
    ////////////////////////////////////////

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_result = rs1_val + opnd_b;
            ALU_SUB: alu_result = rs1_val - opnd_b;
            ALU_AND: alu_result = rs1_val & opnd_b;
            ALU_OR:  alu_result = rs1_val | opnd_b;
            ALU_XOR: alu_result = rs1_val ^ opnd_b;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLL: alu_result = rs1_val << shamt;
            ALU_SRL: alu_result = rs1_val >> shamt;
            default: alu_result = rs1_val + opnd_b;
        endcase
    end

    ////////////////////////////////////////
    // Branch compare
    ////////////////////////////////////////

    // Always register against register
    always_comb begin
        case (branch_funct3)
            FUNCT3_BEQ: cond_true = (rs1_val == rs2_val);
            FUNCT3_BNE: cond_true = (rs1_val != rs2_val);
            FUNCT3_BLT: cond_true = ($signed(rs1_val) < $signed(rs2_val));
            default:    cond_true = 1'b0;
        endcase
    end

endmodule

/* rv_core.sv */
// RV32I multi-cycle core top
`timescale 1ns/10ps

module rv_core (
    input  logic                             aclk,
    input  logic                             arst_n,
    input  logic                             imem_rvalid,
    input  logic [rv_core_pkg::ILEN-1:0]     imem_rdata,
    output logic                             imem_req,
    output logic [rv_core_pkg::XLEN-1:0]     imem_addr,
    output logic                             dmem_wstrobe,
    output logic [rv_core_pkg::XLEN-1:0]     dmem_addr,
    output logic [rv_core_pkg::XLEN-1:0]     dmem_wdata,
    output logic [rv_core_pkg::STATUS_W-1:0] status
);
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    logic              rd_wr;
    logic              alu_use_imm;
    logic              pc_inc;
    logic              pc_load;
    logic              cond_true;
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [REG_AW-1:0] rd_addr;
    logic [XLEN-1:0]   rd_val;
    logic [XLEN-1:0]   rs1_val;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   alu_result;
    logic [2:0]        branch_funct3;
    alu_op_t           alu_op;

    ////////////////////////////////////////
    // Controller
    ////////////////////////////////////////

    rv_control i_rv_control (
        .aclk          (aclk),
        .arst_n        (arst_n),
        .imem_rvalid   (imem_rvalid),
        .imem_rdata    (imem_rdata),
        .cond_true     (cond_true),
        .alu_result    (alu_result),
        .imem_req      (imem_req),
        .dmem_wstrobe  (dmem_wstrobe),
        .rd_wr         (rd_wr),
        .alu_use_imm   (alu_use_imm),
        .pc_inc        (pc_inc),
        .pc_load       (pc_load),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .rd_addr       (rd_addr),
        .rd_val        (rd_val),
        .alu_op        (alu_op),
        .imm           (imm),
        .branch_funct3 (branch_funct3),
        .status        (status)
    );

    // PC drives the fetch address directly
    rv_pc_counter i_rv_pc_counter (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .pc_inc  (pc_inc),
        .pc_load (pc_load),
        .imm     (imm),
        .pc      (imem_addr)
    );

    ////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////

    // rs2 is also the store data
    rv_regfile i_rv_regfile (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .rd_wr    (rd_wr),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .rd_val   (rd_val),
        .rs1_val  (rs1_val),
        .rs2_val  (dmem_wdata)
    );

    assign dmem_addr = alu_result;

    rv_alu i_rv_alu (
        .alu_op        (alu_op),
        .alu_use_imm   (alu_use_imm),
        .rs1_val       (rs1_val),
        .rs2_val       (dmem_wdata),
        .imm           (imm),
        .branch_funct3 (branch_funct3),
        .alu_result    (alu_result),
        .cond_true     (cond_true)
    );

endmodule

/* tb_rv_core.sv */
// Directed testbench for the RV32I core
`timescale 1ns/10ps

module tb_rv_core;
    import rv_core_pkg::*;

    localparam int          CLK_PERIOD   = 8;
    localparam int          IMEM_AW      = 8;
    localparam int          IMEM_WORDS   = 2 ** IMEM_AW;
    localparam int          HALT_WAIT    = 8;
    localparam int          WD_FETCHES   = 200;
    localparam int          WD_CYCLES    = 6;
    localparam logic [2:0]  F3_ADD       = 3'b000;
    localparam logic [2:0]  F3_SLL       = 3'b001;
    localparam logic [2:0]  F3_SLT       = 3'b010;
    localparam logic [2:0]  F3_XOR       = 3'b100;
    localparam logic [2:0]  F3_SRL       = 3'b101;
    localparam logic [2:0]  F3_OR        = 3'b110;
    localparam logic [2:0]  F3_AND       = 3'b111;
    localparam logic [2:0]  F3_BEQ       = 3'b000;
    localparam logic [2:0]  F3_BNE       = 3'b001;
    localparam logic [2:0]  F3_BLT       = 3'b100;
    localparam logic [6:0]  F7_SUB       = 7'b0100000;
    localparam logic [31:0] ECALL_WORD   = 32'h0000_0073;
    localparam logic [31:0] EBREAK_WORD  = 32'h0010_0073;
    localparam logic [31:0] ILLEGAL_WORD = 32'h0000_007f;

    logic                aclk;
    logic                arst_n;
    logic                imem_rvalid;
    logic [ILEN-1:0]     imem_rdata;
    logic                imem_req;
    logic [XLEN-1:0]     imem_addr;
    logic                dmem_wstrobe;
    logic [XLEN-1:0]     dmem_addr;
    logic [XLEN-1:0]     dmem_wdata;
    logic [STATUS_W-1:0] status;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] prog [$];
    logic [31:0] fetch_log [$];
    logic [31:0] st_addr [$];
    logic [31:0] st_data [$];
    logic [31:0] exp_fetch [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    integer      seed        = 32'hb585_79f9;
    int          errors      = 0;
    int          tests_run   = 0;
    int          cycle_cnt   = 0;
    int          last_rvalid = 0;
    logic        first_req   = 1'b1;
    logic        resp_seen   = 1'b0;

    rv_core i_rv_core (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .imem_rvalid  (imem_rvalid),
        .imem_rdata   (imem_rdata),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .dmem_wstrobe (dmem_wstrobe),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .status       (status)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial begin
        #(WD_FETCHES * WD_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d fetches", WD_FETCHES);
        $display("Checks failed");
        $finish;
    end

    ////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////

    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic [6:0] f7,
                                          input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input int rd, input int rs1,
                                          input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), 7'b0010011};
    endfunction

    // SW rs2, imm(rs1)
    function automatic logic [31:0] enc_s(input int rs2, input int rs1, input int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                          input int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_lui(input int rd, input int imm20);
        return {20'(imm20), 5'(rd), 7'b0110111};
    endfunction

    ////////////////////////////////////////
    // Memory model and monitors
    ////////////////////////////////////////

    task automatic flag_error(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // One response per request, 1 to 4 cycles later
    task automatic serve_fetch(input logic [31:0] addr);
        int lat;
        lat = 1 + ($random(seed) & 3);
        repeat (lat) @(posedge aclk);
        #1;
        imem_rvalid = 1'b1;
        imem_rdata  = imem[addr[IMEM_AW+1:2]];
        @(posedge aclk);
        #1;
        imem_rvalid = 1'b0;
    endtask

    initial begin
        imem_rvalid = 1'b0;
        imem_rdata  = '0;
        forever begin
            @(negedge aclk);
            if (arst_n && imem_req) begin
                serve_fetch(imem_addr);
            end
        end
    end

    // Fetch timing, fetch addresses and stores
    always @(negedge aclk) begin
        cycle_cnt++;
        if (!arst_n) begin
            first_req = 1'b1;
            resp_seen = 1'b0;
            fetch_log.delete();
            st_addr.delete();
            st_data.delete();
        end else begin
            if (imem_req && status != '0) begin
                flag_error("fetch request after a trap");
            end
            if (first_req) begin
                if (!imem_req || imem_addr !== BOOT_ADDR) begin
                    flag_error($sformatf("first cycle req %b addr %h, expected a request to %h",
                                         imem_req, imem_addr, BOOT_ADDR));
                end
                first_req = 1'b0;
            end else if (resp_seen && cycle_cnt == last_rvalid + 2) begin
                if (!imem_req && status == '0) begin
                    flag_error("no fetch request 2 cycles after a response");
                end
            end else if (imem_req) begin
                flag_error("fetch request not 2 cycles after a response");
            end
            if (imem_req) begin
                fetch_log.push_back(imem_addr);
            end
            if (imem_rvalid) begin
                last_rvalid = cycle_cnt;
                resp_seen   = 1'b1;
            end
            if (dmem_wstrobe) begin
                st_addr.push_back(dmem_addr);
                st_data.push_back(dmem_wdata);
            end
        end
    end

    ////////////////////////////////////////
    // Test helpers
    ////////////////////////////////////////

    task automatic clear_expect();
        prog.delete();
        exp_fetch.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic expect_linear_fetch(input int n);
        for (int i = 0; i < n; i++) begin
            exp_fetch.push_back(32'(4 * i));
        end
    endtask

    // Load, reset, run until a trap, then idle to catch stray fetches
    task automatic run_program(input int max_fetch);
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = 32'(i) << 7;
        end
        foreach (prog[i]) begin
            imem[i] = prog[i];
        end
        tests_run++;
        @(posedge aclk);
        #1;
        arst_n = 1'b0;
        @(negedge aclk);
        if (imem_req !== 1'b0 || dmem_wstrobe !== 1'b0 || status !== '0) begin
            flag_error($sformatf("in reset req %b wstrobe %b status %b", imem_req,
                                 dmem_wstrobe, status));
        end
        repeat (2) @(posedge aclk);
        #1;
        arst_n = 1'b1;
        while (status == '0 && fetch_log.size() < max_fetch) begin
            @(posedge aclk);
            #1;
        end
        if (status == '0) begin
            flag_error("program did not reach a trap");
        end
        repeat (HALT_WAIT) @(posedge aclk);
        #1;
    endtask

    task automatic compare_results(input logic [STATUS_W-1:0] exp_status);
        if (status !== exp_status) begin
            flag_error($sformatf("status %b, expected %b", status, exp_status));
        end
        if (fetch_log.size() != exp_fetch.size()) begin
            flag_error($sformatf("%0d fetches, expected %0d", fetch_log.size(), exp_fetch.size()));
        end else begin
            foreach (exp_fetch[i]) begin
                if (fetch_log[i] !== exp_fetch[i]) begin
                    flag_error($sformatf("fetch %0d at %h, expected %h", i, fetch_log[i],
                                         exp_fetch[i]));
                end
            end
        end
        if (st_addr.size() != exp_addr.size()) begin
            flag_error($sformatf("%0d stores, expected %0d", st_addr.size(), exp_addr.size()));
        end else begin
            foreach (exp_addr[i]) begin
                if (st_addr[i] !== exp_addr[i] || st_data[i] !== exp_data[i]) begin
                    flag_error($sformatf("store %0d %h <= %h, expected %h <= %h", i, st_addr[i],
                                         st_data[i], exp_addr[i], exp_data[i]));
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic test_reset_fetch();
        clear_expect();
        prog.push_back(enc_i(F3_ADD, 1, 0, 5));
        prog.push_back(enc_s(1, 0, 16));
        prog.push_back(ECALL_WORD);
        expect_linear_fetch(3);
        exp_addr.push_back(32'd16);
        exp_data.push_back(32'd5);
        run_program(8);
        compare_results(STATUS_W'(1 << ST_ECALL));
    endtask

    task automatic test_alu_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] res [14];
        a = 32'h1234_5678;
        b = 32'hffff_fffd;
        c = 32'd4;
        res[0]  = a + b;
        res[1]  = a - b;
        res[2]  = a & b;
        res[3]  = a | b;
        res[4]  = a ^ b;
        res[5]  = ($signed(b) < $signed(c)) ? 32'd1 : 32'd0;
        res[6]  = ($signed(c) < $signed(b)) ? 32'd1 : 32'd0;
        res[7]  = a << c[4:0];
        res[8]  = b >> c[4:0];
        res[9]  = a + 32'hffff_ffff;
        res[10] = a & 32'h0000_00f0;
        res[11] = a | 32'hffff_ff00;
        res[12] = a ^ 32'h0000_07ff;
        res[13] = ($signed(b) < $signed(32'hffff_fffe)) ? 32'd1 : 32'd0;
        clear_expect();
        prog.push_back(enc_lui(1, 32'h12345));
        prog.push_back(enc_i(F3_ADD, 1, 1, 32'h678));
        prog.push_back(enc_i(F3_ADD, 2, 0, -3));
        prog.push_back(enc_i(F3_ADD, 3, 0, 4));
        prog.push_back(enc_r(F3_ADD, 7'b0, 4, 1, 2));
        prog.push_back(enc_r(F3_ADD, F7_SUB, 5, 1, 2));
        prog.push_back(enc_r(F3_AND, 7'b0, 6, 1, 2));
        prog.push_back(enc_r(F3_OR, 7'b0, 7, 1, 2));
        prog.push_back(enc_r(F3_XOR, 7'b0, 8, 1, 2));
        prog.push_back(enc_r(F3_SLT, 7'b0, 9, 2, 3));
        prog.push_back(enc_r(F3_SLT, 7'b0, 10, 3, 2));
        prog.push_back(enc_r(F3_SLL, 7'b0, 11, 1, 3));
        prog.push_back(enc_r(F3_SRL, 7'b0, 12, 2, 3));
        prog.push_back(enc_i(F3_ADD, 13, 1, -1));
        prog.push_back(enc_i(F3_AND, 14, 1, 32'h0f0));
        prog.push_back(enc_i(F3_OR, 15, 1, -256));
        prog.push_back(enc_i(F3_XOR, 16, 1, 32'h7ff));
        prog.push_back(enc_i(F3_SLT, 17, 2, -2));
        for (int k = 0; k < 14; k++) begin
            prog.push_back(enc_s(k + 4, 0, 32'h100 + 4 * k));
            exp_addr.push_back(32'h100 + 32'(4 * k));
            exp_data.push_back(res[k]);
        end
        // Base register plus a negative store offset
        prog.push_back(enc_i(F3_ADD, 18, 0, 32'h200));
        prog.push_back(enc_s(4, 18, -8));
        prog.push_back(ECALL_WORD);
        exp_addr.push_back(32'h1f8);
        exp_data.push_back(res[0]);
        expect_linear_fetch(prog.size());
        run_program(64);
        compare_results(STATUS_W'(1 << ST_ECALL));
    endtask

    task automatic test_branches();
        int path [18] = '{0, 4, 8, 12, 20, 28, 32, 36, 44, 48, 52, 56, 52, 56, 52, 56, 60, 64};
        clear_expect();
        prog.push_back(enc_i(F3_ADD, 1, 0, -5));
        prog.push_back(enc_i(F3_ADD, 2, 0, 3));
        prog.push_back(enc_b(F3_BEQ, 1, 2, 8));
        prog.push_back(enc_b(F3_BNE, 1, 2, 8));
        prog.push_back(enc_s(1, 0, 32'h300));
        prog.push_back(enc_b(F3_BLT, 1, 2, 8));
        prog.push_back(enc_s(2, 0, 32'h304));
        // Signed compare, 3 < -5 is false
        prog.push_back(enc_b(F3_BLT, 2, 1, 8));
        prog.push_back(enc_s(2, 0, 32'h308));
        prog.push_back(enc_b(F3_BEQ, 2, 2, 8));
        prog.push_back(enc_s(1, 0, 32'h30c));
        prog.push_back(enc_b(F3_BNE, 1, 1, 8));
        prog.push_back(enc_s(1, 0, 32'h310));
        // Backward loop, x3 counts up to x2
        prog.push_back(enc_i(F3_ADD, 3, 3, 1));
        prog.push_back(enc_b(F3_BLT, 3, 2, -4));
        prog.push_back(enc_s(3, 0, 32'h314));
        prog.push_back(ECALL_WORD);
        foreach (path[i]) begin
            exp_fetch.push_back(32'(path[i]));
        end
        exp_addr.push_back(32'h308);
        exp_data.push_back(32'd3);
        exp_addr.push_back(32'h310);
        exp_data.push_back(32'hffff_fffb);
        exp_addr.push_back(32'h314);
        exp_data.push_back(32'd3);
        run_program(32);
        compare_results(STATUS_W'(1 << ST_ECALL));
    endtask

    task automatic test_x0();
        clear_expect();
        prog.push_back(enc_i(F3_ADD, 0, 0, 123));
        prog.push_back(enc_i(F3_ADD, 1, 0, 7));
        prog.push_back(enc_r(F3_ADD, 7'b0, 0, 1, 1));
        prog.push_back(enc_s(0, 0, 32'h400));
        prog.push_back(enc_s(0, 0, 32'h404));
        prog.push_back(enc_s(1, 0, 32'h408));
        prog.push_back(ECALL_WORD);
        expect_linear_fetch(7);
        exp_addr.push_back(32'h400);
        exp_data.push_back(32'd0);
        exp_addr.push_back(32'h404);
        exp_data.push_back(32'd0);
        exp_addr.push_back(32'h408);
        exp_data.push_back(32'd7);
        run_program(16);
        compare_results(STATUS_W'(1 << ST_ECALL));
    endtask

    // The store after the trap must never run
    task automatic test_traps();
        logic [31:0]         trap_word [2];
        logic [STATUS_W-1:0] trap_bit [2];
        trap_word[0] = ECALL_WORD;
        trap_word[1] = EBREAK_WORD;
        trap_bit[0]  = STATUS_W'(1 << ST_ECALL);
        trap_bit[1]  = STATUS_W'(1 << ST_EBREAK);
        for (int t = 0; t < 2; t++) begin
            clear_expect();
            prog.push_back(enc_i(F3_ADD, 1, 0, 1));
            prog.push_back(trap_word[t]);
            prog.push_back(enc_s(1, 0, 32'h500));
            prog.push_back(ECALL_WORD);
            expect_linear_fetch(2);
            run_program(8);
            compare_results(trap_bit[t]);
        end
    endtask

    task automatic test_illegal();
        clear_expect();
        prog.push_back(enc_i(F3_ADD, 1, 0, 9));
        prog.push_back(ILLEGAL_WORD);
        prog.push_back(enc_s(1, 0, 32'h600));
        prog.push_back(ECALL_WORD);
        expect_linear_fetch(2);
        run_program(8);
        compare_results(STATUS_W'(1 << ST_ILLEGAL));
    endtask

    initial begin
        arst_n = 1'b0;
        test_reset_fetch();
        test_alu_ops();
        test_branches();
        test_x0();
        test_traps();
        test_illegal();
        $display("Summary: %0d programs run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* rv_core.f */
rv_isa_pkg.sv
rv_core_pkg.sv
rv_control.sv
rv_pc_counter.sv
rv_regfile.sv
rv_alu.sv
rv_core.sv
tb_rv_core.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_rv_core \
    -f rv_core.f \
    && ./obj_dir/Vtb_rv_core | tee /dev/stderr | grep -x "All checks passed" > /dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
